// ==== bench/sram_model.sv ====
module sram_model (
   input  logic [19:0] addr,     // Word address
   input  logic        oe_n,
   input  logic        we_n,
   input  logic        bhe_n,
   input  logic        ble_n,
   input  logic [15:0] din,      // DUT drive side
   input  logic        din_oe,
   output logic [15:0] dout      // DUT receive side
);
   timeunit 1ns;
   timeprecision 1ps;

   // Byte array, even address on the low lane
   logic [7:0] mem [0:(1 << 21) - 1];

   // Hash fill so every address bit changes the byte
   initial begin
      logic [31:0] h;
      for (int i = 0; i < (1 << 21); i++) begin
         h      = i * 32'h9E37_79B1;
         mem[i] = h[31:24];
      end
   end

   // Asynchronous write while WE is low
   always @(*) begin
      if (!we_n && din_oe) begin
         if (!ble_n) mem[{addr, 1'b0}] = din[7:0];
         if (!bhe_n) mem[{addr, 1'b1}] = din[15:8];
      end
   end

   assign dout[15:8] = (!oe_n && !bhe_n) ? mem[{addr, 1'b1}] : 8'h00;
   assign dout[7:0]  = (!oe_n && !ble_n) ? mem[{addr, 1'b0}] : 8'h00;

endmodule

// ==== bench/tb_cart_mem_ctrl.sv ====
module tb_cart_mem_ctrl;
   timeunit 1ns;
   timeprecision 1ps;

   localparam logic [20:0] SAV_BASE = 21'h1C_0000;
   localparam int HOST_MAX = 12 + 6 + 2;   // Sequence plus 6, plus stb and ack clocks

   logic CLK2, rst_n;
   cart_pkg::snes_addr_t snes_addr;
   logic snes_rd_n, snes_wr_n, snes_cs_n;
   logic [7:0] snes_data_in, snes_data_out;
   logic snes_data_oe;
   logic [3:0] wb_adr;
   logic [7:0] wb_dat_i, wb_dat_o;
   logic wb_we, wb_cyc, wb_stb, wb_ack;
   cart_pkg::sram_addr_t sram_addr;
   logic sram_oe_n, sram_we_n, sram_bhe_n, sram_ble_n;
   logic [15:0] sram_data_in, sram_data_out;
   logic sram_data_oe;

   int errors, tests, failed_tests, n;
   logic [20:0] rom_mask, sav_mask;   // Copies of what the DUT was given
   logic hirom;

   tb_clock u_clock (.*);
   cart_mem_ctrl #(.SAVERAM_BASE(SAV_BASE)) UUT (.*);
   sram_model u_sram (
      .addr(sram_addr), .oe_n(sram_oe_n), .we_n(sram_we_n), .bhe_n(sram_bhe_n),
      .ble_n(sram_ble_n), .din(sram_data_out), .din_oe(sram_data_oe), .dout(sram_data_in)
   );

   ////////////////////////////////////////
   // Reference map and bus drivers
   ////////////////////////////////////////

   // Byte address from the LoROM/HiROM rules, 0 on no hit
   function automatic logic expected_addr(input logic [23:0] a, input logic cs_n,
                                          output logic [20:0] b);
      logic [7:0]  bank;
      logic [21:0] off;
      bank = a[23:16];
      b    = '0;
      if (!hirom && bank >= 8'h70 && bank <= 8'h7D && !a[15]) begin
         b = SAV_BASE + ({2'b00, bank[3:0], a[14:0]} & sav_mask);
         return 1'b1;
      end
      if (hirom && bank[6:0] >= 7'h20 && bank[6:0] <= 7'h3F && a[15:13] == 3'b011) begin
         b = SAV_BASE + ({3'b000, bank[4:0], a[12:0]} & sav_mask);
         return 1'b1;
      end
      off = hirom ? a[21:0] : {bank[6:0], a[14:0]};
      b   = off[20:0] & rom_mask;
      return (hirom ? (bank[6] | a[15]) : a[15]) && !cs_n;   // ROM needs /CART
   endfunction

   // 16 clocks of RD or WR low, sampled in the 12th
   task automatic console_cycle(input logic [23:0] a, input logic cs_n, input logic wr,
                                input logic [7:0] wdata, output logic [7:0] rdata,
                                output logic oe);
      @(posedge CLK2);
      #2;
      snes_addr    = a;
      snes_cs_n    = cs_n;
      snes_data_in = wdata;
      if (wr) snes_wr_n = 1'b0;
      else snes_rd_n = 1'b0;
      for (int k = 1; k <= 16; k++) begin
         @(posedge CLK2);
         if (k == 11) begin
            @(negedge CLK2);   // Middle of the 12th clock
            rdata = snes_data_out;
            oe    = snes_data_oe;
         end
      end
      #2;
      snes_rd_n = 1'b1;
      snes_wr_n = 1'b1;
      snes_cs_n = 1'b1;
      repeat (2) @(posedge CLK2);   // Strobes high long enough to resync
   endtask

   // Console read checked against the model at the mapped address
   task automatic mapped_read(input logic [23:0] a, input logic cs_n);
      logic [7:0]  d;
      logic [20:0] b;
      logic        oe, hit;
      hit = expected_addr(a, cs_n, b);
      console_cycle(a, cs_n, 1'b0, 8'h00, d, oe);
      if (oe !== hit) begin
         $display("FAIL snes_data_oe: got %h expected %h at %h", oe, hit, a);
         errors++;
      end else if (hit && d !== u_sram.mem[b]) begin
         $display("FAIL snes_data_out: got %h expected %h at %h", d, u_sram.mem[b], a);
         errors++;
      end
   endtask

   // One Wishbone classic cycle, lat counts clocks to ack
   task automatic bus_access(input logic [3:0] adr, input logic we, input logic [7:0] wdata,
                             output logic [7:0] rdata, output int lat);
      int cnt;
      @(posedge CLK2);
      #2;
      wb_adr   = adr;
      wb_we    = we;
      wb_dat_i = wdata;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      cnt      = 0;
      rdata    = 8'h00;
      do begin
         @(negedge CLK2);   // Ack is registered
         cnt++;
      end while (!wb_ack && cnt < 64);
      if (wb_ack) rdata = wb_dat_o;
      else begin
         $display("Timeout waiting for Wishbone ack at register %0d", adr);
         errors++;
      end
      lat = cnt;
      @(posedge CLK2);
      #2;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic write_reg(input logic [3:0] adr, input logic [7:0] d);
      logic [7:0] unused;
      int         lat;
      bus_access(adr, 1'b1, d, unused, lat);
   endtask

   task automatic read_reg(input logic [3:0] adr, output logic [7:0] d);
      int lat;
      bus_access(adr, 1'b0, 8'h00, d, lat);
   endtask

   task automatic set_host_addr(input logic [20:0] a);
      write_reg(4'd1, a[7:0]);
      write_reg(4'd2, a[15:8]);
      write_reg(4'd3, {3'b000, a[20:16]});
   endtask

   task automatic set_rom_mask(input logic [20:0] m);
      write_reg(4'd5, m[7:0]);
      write_reg(4'd6, m[15:8]);
      write_reg(4'd7, {3'b000, m[20:16]});
      rom_mask = m;
   endtask

   task automatic set_sav_mask(input logic [20:0] m);
      write_reg(4'd8, m[7:0]);
      write_reg(4'd9, m[15:8]);
      write_reg(4'd10, {3'b000, m[20:16]});
      sav_mask = m;
   endtask

   task automatic finish_test(input string name, input int e0);
      tests++;
      if (errors == e0) $display("Test %s: ok", name);
      else begin
         failed_tests++;
         $display("Test %s: %0d errors", name, errors - e0);
      end
   endtask

   ////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////

   task automatic check_reset();
      logic [7:0] d;
      int         e0;
      e0 = errors;
      @(negedge CLK2);
      if ({sram_oe_n, sram_we_n, sram_bhe_n, sram_ble_n} !== 4'hF) begin
         $display("FAIL sram strobes: got %h expected %h",
                  {sram_oe_n, sram_we_n, sram_bhe_n, sram_ble_n}, 4'hF);
         errors++;
      end
      if ({snes_data_oe, sram_data_oe, wb_ack} !== 3'b000) begin
         $display("FAIL oe/ack: got %h expected %h", {snes_data_oe, sram_data_oe, wb_ack}, 3'b000);
         errors++;
      end
      read_reg(4'd0, d);
      if (d !== 8'h00) begin
         $display("FAIL wb_dat_o mapper: got %h expected %h", d, 8'h00);
         errors++;
      end
      finish_test("reset state", e0);
   endtask

   task automatic readback_regs();
      logic [7:0] exp [1:10];
      logic [7:0] d;
      int         e0;
      e0 = errors;
      for (int r = 1; r <= 10; r++) begin
         if (r == 4) continue;   // Data register has no storage
         exp[r] = 8'($urandom);
         if (r == 3 || r == 7 || r == 10) exp[r] = exp[r] & 8'h1F;   // Top of a 21-bit value
         write_reg(4'(r), exp[r]);
      end
      for (int r = 1; r <= 10; r++) begin
         if (r == 4) continue;
         read_reg(4'(r), d);
         if (d !== exp[r]) begin
            $display("FAIL wb_dat_o reg %0d: got %h expected %h", r, d, exp[r]);
            errors++;
         end
      end
      set_rom_mask(21'h0F_FFFF);
      set_sav_mask(21'h00_1FFF);
      finish_test("register readback", e0);
   endtask

   task automatic host_data_access();
      logic [20:0] base;
      logic [7:0]  wd [4];
      logic [7:0]  below, above, d;
      int          e0;
      e0    = errors;
      base  = 21'h0A_BCD5;   // Odd start, both lanes
      below = u_sram.mem[base - 21'd1];
      above = u_sram.mem[base + 21'd4];
      set_host_addr(base);
      for (int i = 0; i < 4; i++) begin
         wd[i] = 8'($urandom);
         write_reg(4'd4, wd[i]);
      end
      for (int i = 0; i < 4; i++) begin
         if (u_sram.mem[base + 21'(i)] !== wd[i]) begin
            $display("FAIL sram byte %h: got %h expected %h", base + 21'(i),
                     u_sram.mem[base + 21'(i)], wd[i]);
            errors++;
         end
      end
      if (u_sram.mem[base - 21'd1] !== below || u_sram.mem[base + 21'd4] !== above) begin
         $display("Host writes disturbed a byte next to the written range");
         errors++;
      end
      read_reg(4'd1, d);
      if (d !== 8'(base + 21'd4)) begin
         $display("FAIL host_addr low: got %h expected %h", d, 8'(base + 21'd4));
         errors++;
      end
      set_host_addr(base);
      for (int i = 0; i < 4; i++) begin
         read_reg(4'd4, d);
         if (d !== wd[i]) begin
            $display("FAIL wb_dat_o data: got %h expected %h", d, wd[i]);
            errors++;
         end
      end
      finish_test("host data access", e0);
   endtask

   task automatic lorom_reads();
      logic [23:0] a;
      int          e0;
      e0 = errors;
      for (int i = 0; i < 6; i++) begin
         a     = 24'($urandom);
         a[15] = 1'b1;   // ROM half
         mapped_read(a, 1'b0);
      end
      for (int i = 0; i < 6; i++) begin
         a = {8'h70 + 8'($urandom % 14), 1'b0, 15'($urandom)};
         mapped_read(a, 1'b1);   // Save RAM ignores /CART
      end
      mapped_read(24'h00_1234, 1'b0);   // Low half outside 70-7D
      mapped_read(24'h01_9ABC, 1'b1);   // ROM without /CART
      finish_test("LoROM reads", e0);
   endtask

   task automatic hirom_write_masks();
      logic [23:0] a;
      logic [20:0] b, far;
      logic [7:0]  wd, nb, fb, d;
      logic        oe;
      int          e0;
      e0 = errors;
      write_reg(4'd0, 8'h01);
      hirom = 1'b1;
      set_sav_mask(21'h00_07FF);
      a = 24'hA3_7ABC;   // Bank A3, window 6000-7FFF
      void'(expected_addr(a, 1'b1, b));
      far = SAV_BASE + 21'h00_7ABC;   // Where it would land unmasked
      wd  = ~u_sram.mem[b];
      nb  = u_sram.mem[b ^ 21'd1];
      fb  = u_sram.mem[far];
      console_cycle(a, 1'b1, 1'b1, wd, d, oe);
      if (u_sram.mem[b] !== wd) begin
         $display("FAIL sram byte %h: got %h expected %h", b, u_sram.mem[b], wd);
         errors++;
      end
      if (u_sram.mem[b ^ 21'd1] !== nb || u_sram.mem[far] !== fb) begin
         $display("Console write changed a byte outside the masked address");
         errors++;
      end
      if (oe !== 1'b0) begin
         $display("FAIL snes_data_oe: got %h expected %h", oe, 1'b0);
         errors++;
      end
      set_rom_mask(21'h03_FFFF);
      mapped_read(24'hC5_1234, 1'b0);
      mapped_read(24'h45_F00D, 1'b0);
      mapped_read(24'h12_9ABC, 1'b0);
      finish_test("HiROM write and masks", e0);
   endtask

   task automatic interleaved_access();
      logic [20:0] base;
      logic [7:0]  wd [4];
      logic [7:0]  d;
      int          lat, e0;
      e0   = errors;
      base = 21'h15_0000;   // Clear of ROM and save RAM
      write_reg(4'd0, 8'h00);
      hirom = 1'b0;
      set_rom_mask(21'h0F_FFFF);
      set_sav_mask(21'h00_1FFF);
      set_host_addr(base);
      fork
         for (int i = 0; i < 14; i++) mapped_read({8'($urandom), 1'b1, 15'($urandom)}, 1'b0);
         begin
            repeat (5) @(posedge CLK2);   // Land inside the first console cycle
            for (int i = 0; i < 8; i++) begin
               if (i == 4) set_host_addr(base);
               if (i < 4) wd[i] = 8'($urandom);
               bus_access(4'd4, i < 4, wd[i % 4], d, lat);
               if (lat > HOST_MAX) begin
                  $display("Host access %0d took %0d clocks, limit %0d", i, lat, HOST_MAX);
                  errors++;
               end
               if (i >= 4 && d !== wd[i - 4]) begin
                  $display("FAIL wb_dat_o data: got %h expected %h", d, wd[i - 4]);
                  errors++;
               end
            end
         end
      join
      finish_test("interleaved access", e0);
   endtask

   initial begin
      void'($urandom(32'h1515_569a));
      errors       = 0;
      tests        = 0;
      failed_tests = 0;
      hirom        = 1'b0;
      rom_mask     = 21'h0F_FFFF;
      sav_mask     = 21'h00_1FFF;
      snes_addr    = '0;
      snes_rd_n    = 1'b1;
      snes_wr_n    = 1'b1;
      snes_cs_n    = 1'b1;
      snes_data_in = 8'h00;
      wb_adr       = 4'd0;
      wb_dat_i     = 8'h00;
      wb_we        = 1'b0;
      wb_cyc       = 1'b0;
      wb_stb       = 1'b0;
      n = 0;
      while (rst_n !== 1'b1 && n < 20) begin
         @(posedge CLK2);
         n++;
      end
      if (rst_n !== 1'b1) begin
         $display("Reset was never released");
         errors++;
      end
      check_reset();
      readback_regs();
      host_data_access();
      lorom_reads();
      hirom_write_masks();
      interleaved_access();
      $display("Tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
      if (errors == 0) $display("All checks passed");
      else $display("Checks failed");
      $finish;
   end

endmodule

// ==== bench/tb_clock.sv ====
module tb_clock (
   output logic CLK2,
   output logic rst_n
);
   timeunit 1ns;
   timeprecision 1ps;

   // 50 MHz slot clock
   initial begin
      CLK2 = 1'b0;
      forever #10 CLK2 = ~CLK2;
   end

   // Reset held for three rising edges
   initial begin
      rst_n = 1'b0;
      repeat (3) @(posedge CLK2);
      #2;
      rst_n = 1'b1;
   end

endmodule

// ==== cart_mem_ctrl.f ====
hw/cart_pkg.sv
hw/bus_pkg.sv
hw/host_regs.sv
hw/addr_map.sv
hw/slot_sequencer.sv
hw/data_path.sv
hw/cart_mem_ctrl.sv
bench/tb_clock.sv
bench/sram_model.sv
bench/tb_cart_mem_ctrl.sv

// ==== hw/addr_map.sv ====
module addr_map #(
   parameter cart_pkg::byte_addr_t SAVERAM_BASE = 21'h1C_0000
) (
   input  cart_pkg::snes_addr_t snes_addr,
   input  logic                 snes_cs_n,
   input  cart_pkg::cart_cfg_t  cart_cfg,
   input  bus_pkg::host_req_t   host_req,
   input  bus_pkg::slot_ctrl_t  slot_ctrl,
   output cart_pkg::sram_addr_t sram_addr,
   output logic                 addr0,        // High byte lane
   output logic                 console_hit,
   output logic                 console_is_rom
);

   logic [7:0]           bank;
   logic                 lo_sav;
   logic                 lo_rom;
   logic                 hi_sav;
   logic                 hi_rom;
   logic                 is_sav;
   logic                 is_rom;
   logic [18:0]          sav_off;
   cart_pkg::byte_addr_t rom_off;
   cart_pkg::byte_addr_t rom_byte;
   cart_pkg::byte_addr_t sav_byte;
   cart_pkg::byte_addr_t con_byte;
   cart_pkg::byte_addr_t sel_byte;

   assign bank = snes_addr[23:16];

   // LoROM save RAM in banks 70-7D, lower half
   assign lo_sav = (bank >= 8'h70) && (bank <= 8'h7D) && !snes_addr[15];
   assign lo_rom = snes_addr[15];
   // HiROM save RAM at 6000-7FFF of banks 20-3F and A0-BF
   assign hi_sav = (bank[6:5] == 2'b01) && (snes_addr[15:13] == 3'b011);
   assign hi_rom = bank[6] | snes_addr[15];

   ////////////////////////////////////////
   // Offsets per layout
   ////////////////////////////////////////

   // ROM offset bits above 20 fall outside the SRAM and the mask
   always_comb begin
      if (cart_cfg.mapper == cart_pkg::HIROM) begin
         is_sav  = hi_sav;
         is_rom  = !hi_sav && hi_rom;
         sav_off = {1'b0, bank[4:0], snes_addr[12:0]};
         rom_off = snes_addr[20:0];
      end else begin
         is_sav  = lo_sav;
         is_rom  = !lo_sav && lo_rom;
         sav_off = {bank[3:0], snes_addr[14:0]};
         rom_off = {bank[5:0], snes_addr[14:0]};   // Bank bit 6 dropped
      end
   end

   assign rom_byte = rom_off & cart_cfg.rom_mask;
   assign sav_byte = SAVERAM_BASE + ({2'b00, sav_off} & cart_cfg.saveram_mask);

   // ROM needs /CART low, save RAM does not
   assign console_is_rom = is_rom & !snes_cs_n;
   assign console_hit    = is_sav | console_is_rom;
   assign con_byte       = is_sav ? sav_byte : rom_byte;

   // Host owns the address bus in its slot
   assign sel_byte  = slot_ctrl.host_slot ? host_req.addr : con_byte;
   assign sram_addr = sel_byte[20:1];
   assign addr0     = sel_byte[0];

endmodule

// ==== hw/bus_pkg.sv ====
package bus_pkg;

   ////////////////////////////////////////
   // Slot schedule
   ////////////////////////////////////////

   // S0-S5 console slot, S6-S11 host slot
   typedef enum logic [3:0] {
      S0   = 4'd0,
      S1   = 4'd1,
      S2   = 4'd2,
      S3   = 4'd3,
      S4   = 4'd4,
      S5   = 4'd5,
      S6   = 4'd6,
      S7   = 4'd7,
      S8   = 4'd8,
      S9   = 4'd9,
      S10  = 4'd10,
      S11  = 4'd11,
      IDLE = 4'd12
   } slot_state_e;

   // Per-clock strobes from the sequencer
   typedef struct packed {
      logic host_slot;       // S6-S11, address from host
      logic sram_oe;         // Active high here, inverted at the pins
      logic sram_we;
      logic latch_console;   // Capture console byte
      logic latch_host;      // Capture host read byte
      logic host_done;       // Host access finished
   } slot_ctrl_t;

   // One outstanding host SRAM access
   typedef struct packed {
      logic                 valid;
      logic                 write;
      cart_pkg::byte_addr_t addr;
      logic [7:0]           data;   // Write data
   } host_req_t;

endpackage

// ==== hw/cart_mem_ctrl.sv ====
module cart_mem_ctrl #(
   parameter cart_pkg::byte_addr_t SAVERAM_BASE = 21'h1C_0000
) (
   input  logic                 CLK2,
   input  logic                 rst_n,
   // Console CPU bus
   input  cart_pkg::snes_addr_t snes_addr,
   input  logic                 snes_rd_n,
   input  logic                 snes_wr_n,
   input  logic                 snes_cs_n,
   input  logic [7:0]           snes_data_in,
   output logic [7:0]           snes_data_out,
   output logic                 snes_data_oe,
   // Host Wishbone port
   input  logic [3:0]           wb_adr,
   input  logic [7:0]           wb_dat_i,
   output logic [7:0]           wb_dat_o,
   input  logic                 wb_we,
   input  logic                 wb_cyc,
   input  logic                 wb_stb,
   output logic                 wb_ack,
   // SRAM
   output cart_pkg::sram_addr_t sram_addr,
   output logic                 sram_oe_n,
   output logic                 sram_we_n,
   output logic                 sram_bhe_n,
   output logic                 sram_ble_n,
   input  logic [15:0]          sram_data_in,
   output logic [15:0]          sram_data_out,
   output logic                 sram_data_oe
);

   cart_pkg::cart_cfg_t cart_cfg;
   bus_pkg::host_req_t  host_req;
   bus_pkg::slot_ctrl_t slot_ctrl;
   logic [7:0]          host_rdata;
   logic                addr0;
   logic                console_hit;

   host_regs u_host_regs (
      .CLK2(CLK2), .rst_n(rst_n),
      .wb_adr(wb_adr), .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o),
      .wb_we(wb_we), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack),
      .host_rdata(host_rdata), .host_done(slot_ctrl.host_done),
      .cart_cfg(cart_cfg), .host_req(host_req)
   );

   // ROM flag not needed outside the decoder here
   addr_map #(.SAVERAM_BASE(SAVERAM_BASE)) u_addr_map (
      .snes_addr(snes_addr), .snes_cs_n(snes_cs_n), .cart_cfg(cart_cfg),
      .host_req(host_req), .slot_ctrl(slot_ctrl), .sram_addr(sram_addr),
      .addr0(addr0), .console_hit(console_hit), .console_is_rom()
   );

   slot_sequencer u_slot_sequencer (
      .CLK2(CLK2), .rst_n(rst_n),
      .snes_rd_n(snes_rd_n), .snes_wr_n(snes_wr_n),
      .console_hit(console_hit), .host_req(host_req), .addr0(addr0),
      .slot_ctrl(slot_ctrl),
      .sram_oe_n(sram_oe_n), .sram_we_n(sram_we_n),
      .sram_bhe_n(sram_bhe_n), .sram_ble_n(sram_ble_n)
   );

   data_path u_data_path (
      .CLK2(CLK2), .rst_n(rst_n),
      .slot_ctrl(slot_ctrl), .addr0(addr0), .snes_rd_n(snes_rd_n),
      .console_hit(console_hit), .host_req(host_req),
      .snes_data_in(snes_data_in), .snes_data_out(snes_data_out),
      .snes_data_oe(snes_data_oe),
      .sram_data_in(sram_data_in), .sram_data_out(sram_data_out),
      .sram_data_oe(sram_data_oe), .host_rdata(host_rdata)
   );

endmodule

// ==== hw/cart_pkg.sv ====
package cart_pkg;

   ////////////////////////////////////////
   // Address widths
   ////////////////////////////////////////

   // Byte address inside the SRAM, 2 MB
   typedef logic [20:0] byte_addr_t;

   // Console CPU bus address, bank plus offset
   typedef logic [23:0] snes_addr_t;

   // SRAM word address, 16-bit words
   typedef logic [19:0] sram_addr_t;

   ////////////////////////////////////////
   // Cartridge layout
   ////////////////////////////////////////

   typedef enum logic {
      LOROM = 1'b0,   // 32 KB ROM pages at 8000-FFFF
      HIROM = 1'b1    // 64 KB ROM banks
   } mapper_e;

   // Configuration from the host register block
   typedef struct packed {
      mapper_e    mapper;
      byte_addr_t rom_mask;       // ANDed onto ROM offsets
      byte_addr_t saveram_mask;   // ANDed onto save RAM offsets
   } cart_cfg_t;

   // Reset values of the configuration
   localparam byte_addr_t ROM_MASK_RST     = 21'h0F_FFFF;
   localparam byte_addr_t SAVERAM_MASK_RST = 21'h00_1FFF;

endpackage

// ==== hw/data_path.sv ====
module data_path (
   input  logic                CLK2,
   input  logic                rst_n,
   input  bus_pkg::slot_ctrl_t slot_ctrl,
   input  logic                addr0,
   input  logic                snes_rd_n,
   input  logic                console_hit,
   input  bus_pkg::host_req_t  host_req,
   // Console data pins
   input  logic [7:0]          snes_data_in,
   output logic [7:0]          snes_data_out,
   output logic                snes_data_oe,
   // SRAM data pins
   input  logic [15:0]         sram_data_in,
   output logic [15:0]         sram_data_out,
   output logic                sram_data_oe,
   output logic [7:0]          host_rdata
);

   logic [7:0] lane_byte;   // Selected SRAM byte
   logic [7:0] con_rdata;
   logic [7:0] con_wdata;
   logic [7:0] wr_byte;

   assign lane_byte = addr0 ? sram_data_in[15:8] : sram_data_in[7:0];

   ////////////////////////////////////////
   // Read capture
   ////////////////////////////////////////

   always_ff @(posedge CLK2 or negedge rst_n) begin
      if (!rst_n) begin
         con_rdata  <= 8'd0;
         host_rdata <= 8'd0;
      end else begin
         if (slot_ctrl.latch_console) con_rdata  <= lane_byte;   // Held through S5 on
         if (slot_ctrl.latch_host)    host_rdata <= lane_byte;
      end
   end

   // Console write byte, taken in S1
   always_ff @(posedge CLK2) begin
      if (slot_ctrl.latch_console) con_wdata <= snes_data_in;
   end

   ////////////////////////////////////////
   // Drivers
   ////////////////////////////////////////

   // Same byte on both lanes, BHE/BLE pick one
   assign wr_byte       = slot_ctrl.host_slot ? host_req.data : con_wdata;
   assign sram_data_out = {wr_byte, wr_byte};
   assign sram_data_oe  = slot_ctrl.sram_we;

   // Console bus driven only for mapped reads
   assign snes_data_out = con_rdata;
   assign snes_data_oe  = ~snes_rd_n & console_hit;

endmodule

// ==== hw/host_regs.sv ====
module host_regs (
   input  logic                CLK2,
   input  logic                rst_n,
   // Wishbone classic slave
   input  logic [3:0]          wb_adr,
   input  logic [7:0]          wb_dat_i,
   output logic [7:0]          wb_dat_o,
   input  logic                wb_we,
   input  logic                wb_cyc,
   input  logic                wb_stb,
   output logic                wb_ack,
   // SRAM side
   input  logic [7:0]          host_rdata,
   input  logic                host_done,
   output cart_pkg::cart_cfg_t cart_cfg,
   output bus_pkg::host_req_t  host_req
);

   localparam logic [3:0] DATA_REG = 4'd4;

   cart_pkg::mapper_e    mapper;
   cart_pkg::byte_addr_t rom_mask;
   cart_pkg::byte_addr_t saveram_mask;
   cart_pkg::byte_addr_t host_addr;   // Auto-increments per data access
   logic                 req_valid;
   logic                 req_write;
   logic [7:0]           req_data;
   logic                 reg_acc;
   logic                 data_acc;
   logic                 issue;

   // New strobe, not yet acked
   assign reg_acc  = wb_cyc & wb_stb & ~wb_ack & (wb_adr != DATA_REG);
   assign data_acc = wb_cyc & wb_stb & ~wb_ack & (wb_adr == DATA_REG);
   assign issue    = data_acc & ~req_valid;   // One request at a time

   ////////////////////////////////////////
   // Registers and handshake
   ////////////////////////////////////////

   always_ff @(posedge CLK2 or negedge rst_n) begin
      if (!rst_n) begin
         mapper       <= cart_pkg::LOROM;
         rom_mask     <= cart_pkg::ROM_MASK_RST;
         saveram_mask <= cart_pkg::SAVERAM_MASK_RST;
         host_addr    <= '0;
         req_valid    <= 1'b0;
         req_write    <= 1'b0;
         wb_ack       <= 1'b0;
      end else begin
         wb_ack <= 1'b0;   // Single clock pulse
         if (reg_acc) begin
            wb_ack <= 1'b1;   // Plain registers ack next clock
            if (wb_we) begin
               case (wb_adr)
                  4'd0:  mapper              <= cart_pkg::mapper_e'(wb_dat_i[0]);
                  4'd1:  host_addr[7:0]      <= wb_dat_i;
                  4'd2:  host_addr[15:8]     <= wb_dat_i;
                  4'd3:  host_addr[20:16]    <= wb_dat_i[4:0];
                  4'd5:  rom_mask[7:0]       <= wb_dat_i;
                  4'd6:  rom_mask[15:8]      <= wb_dat_i;
                  4'd7:  rom_mask[20:16]     <= wb_dat_i[4:0];
                  4'd8:  saveram_mask[7:0]   <= wb_dat_i;
                  4'd9:  saveram_mask[15:8]  <= wb_dat_i;
                  4'd10: saveram_mask[20:16] <= wb_dat_i[4:0];
                  default: ;
               endcase
            end
         end
         if (issue) begin
            req_valid <= 1'b1;   // Held until host_done
            req_write <= wb_we;
         end
         // Sequencer finished the access
         if (host_done) begin
            req_valid <= 1'b0;
            host_addr <= host_addr + 1'b1;
            wb_ack    <= 1'b1;
         end
      end
   end

   // Write byte for the SRAM
   always_ff @(posedge CLK2) begin
      if (issue && wb_we) req_data <= wb_dat_i;
   end

   ////////////////////////////////////////
   // Read mux
   ////////////////////////////////////////

   always_comb begin
      case (wb_adr)
         4'd0:    wb_dat_o = {7'd0, mapper};
         4'd1:    wb_dat_o = host_addr[7:0];
         4'd2:    wb_dat_o = host_addr[15:8];
         4'd3:    wb_dat_o = {3'd0, host_addr[20:16]};
         DATA_REG: wb_dat_o = host_rdata;   // Byte from last host read
         4'd5:    wb_dat_o = rom_mask[7:0];
         4'd6:    wb_dat_o = rom_mask[15:8];
         4'd7:    wb_dat_o = {3'd0, rom_mask[20:16]};
         4'd8:    wb_dat_o = saveram_mask[7:0];
         4'd9:    wb_dat_o = saveram_mask[15:8];
         4'd10:   wb_dat_o = {3'd0, saveram_mask[20:16]};
         default: wb_dat_o = 8'd0;
      endcase
   end

   assign cart_cfg = '{mapper: mapper, rom_mask: rom_mask, saveram_mask: saveram_mask};
   assign host_req = '{valid: req_valid, write: req_write, addr: host_addr, data: req_data};

endmodule

// ==== hw/slot_sequencer.sv ====
module slot_sequencer (
   input  logic                CLK2,
   input  logic                rst_n,
   input  logic                snes_rd_n,
   input  logic                snes_wr_n,
   input  logic                console_hit,
   input  bus_pkg::host_req_t  host_req,
   input  logic                addr0,
   output bus_pkg::slot_ctrl_t slot_ctrl,
   output logic                sram_oe_n,
   output logic                sram_we_n,
   output logic                sram_bhe_n,
   output logic                sram_ble_n
);

   bus_pkg::slot_state_e state;
   bus_pkg::slot_state_e state_nxt;
   logic [2:0]           rw_q;       // Two sync stages plus edge history
   logic [1:0]           rd_q;
   logic                 start;
   logic                 cyc_read;   // Console cycle is a read
   logic                 host_act;   // Host slot in use
   logic                 host_wr;
   logic                 in_con;
   logic                 in_host;

   // Falling edge of /RD AND /WR opens a console cycle
   assign start = rw_q[2] & ~rw_q[1];

   ////////////////////////////////////////
   // Synchronizer and state register
   ////////////////////////////////////////

   always_ff @(posedge CLK2 or negedge rst_n) begin
      if (!rst_n) begin
         rw_q     <= 3'b111;
         rd_q     <= 2'b11;
         state    <= bus_pkg::IDLE;
         cyc_read <= 1'b0;
         host_act <= 1'b0;
         host_wr  <= 1'b0;
      end else begin
         rw_q  <= {rw_q[1:0], snes_rd_n & snes_wr_n};
         rd_q  <= {rd_q[0], snes_rd_n};   // Aligned with rw_q[1]
         state <= state_nxt;
         if (start) cyc_read <= ~rd_q[1];
         // Host slot decided at S6
         if (state == bus_pkg::S6) begin
            host_act <= host_req.valid;
            host_wr  <= host_req.write;
         end
      end
   end

   always_comb begin
      if (start) begin
         state_nxt = bus_pkg::S0;   // Restart wins, host access retried later
      end else begin
         case (state)
            bus_pkg::IDLE: state_nxt = host_req.valid ? bus_pkg::S6 : bus_pkg::IDLE;
            bus_pkg::S11:  state_nxt = bus_pkg::IDLE;
            default:       state_nxt = bus_pkg::slot_state_e'(state + 4'd1);
         endcase
      end
   end

   ////////////////////////////////////////
   // Strobe decode
   ////////////////////////////////////////

   assign in_con  = (state <= bus_pkg::S5);
   assign in_host = (state >= bus_pkg::S6) && (state <= bus_pkg::S11);

   always_comb begin
      slot_ctrl.host_slot = in_host;
      // Console read S1-S5, write S2-S4, hit only
      slot_ctrl.sram_oe = in_con && cyc_read && console_hit &&
                          (state >= bus_pkg::S1);
      slot_ctrl.sram_we = in_con && !cyc_read && console_hit &&
                          (state >= bus_pkg::S2) && (state <= bus_pkg::S4);
      // Host read S7-S10, write S8-S10
      if (in_host && host_act) begin
         if (host_wr) begin
            slot_ctrl.sram_we = (state >= bus_pkg::S8) && (state <= bus_pkg::S10);
         end else begin
            slot_ctrl.sram_oe = (state >= bus_pkg::S7) && (state <= bus_pkg::S10);
         end
      end
      // Write data taken before WE, read data in S4
      slot_ctrl.latch_console = cyc_read ? (state == bus_pkg::S4) : (state == bus_pkg::S1);
      slot_ctrl.latch_host    = host_act && !host_wr && (state == bus_pkg::S10);
      slot_ctrl.host_done     = host_act && (state == bus_pkg::S11);
   end

   // Active low pins
   assign sram_oe_n  = ~slot_ctrl.sram_oe;
   assign sram_we_n  = ~slot_ctrl.sram_we;
   assign sram_bhe_n = ~(slot_ctrl.sram_oe | (slot_ctrl.sram_we & addr0));   // Both on reads
   assign sram_ble_n = ~(slot_ctrl.sram_oe | (slot_ctrl.sram_we & ~addr0));

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cartridge memory controller testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
   --top-module tb_cart_mem_ctrl -Mdir obj_dir -f cart_mem_ctrl.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vtb_cart_mem_ctrl > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "Checks failed" "$LOG"; then
   exit 1
fi
exit 0
